// ==== source/positDefs.sv ====
/*
 * Posit field definitions
 *   posit_t, the raw posit word
 *   width functions for decoded and product scale and fraction fields
 */
package positDefs;

  typedef logic [7:0] posit_t;  // raw posit as it enters the array

  // largest scale reached by maxpos, the regime contributes (width-2) << es
  function automatic int maxScale(input int width, input int es);
    return (width - 2) << es;
  endfunction

  // signed width holding -maxScale..maxScale
  function automatic int scaleBits(input int width, input int es);
    return $clog2(maxScale(width, es) + 1) + 1;
  endfunction

  // sign, regime and terminator take at least three bits
  function automatic int fracBits(input int width, input int es);
    return width - 3 - es;
  endfunction

  function automatic int productScaleBits(input int width, input int es);
    return scaleBits(width, es) + 1;  // sum of two scales plus the normalization step
  endfunction

  function automatic int productFracBits(input int width, input int es);
    return 2 * (fracBits(width, es) + 1);  // exact product of two significands
  endfunction

endpackage

// ==== source/quireDefs.sv ====
/*
 * Quire (Kulisch accumulator) definitions
 *   quire_t, the fixed-point accumulator word
 *   sizing functions for the fraction and integer parts
 */
package quireDefs;

  // holds the 60-bit quire of the default posit<8,1> with two guard bits
  typedef logic signed [63:0] quire_t;

  // reaches down to minpos squared with every product fraction bit kept
  function automatic int fracBits(input int width, input int es);
    return 2 * positDefs::maxScale(width, es) + 2 * positDefs::fracBits(width, es);
  endfunction

  // maxpos squared, its significand carry and sign, plus the guard bits
  function automatic int nonFracBits(input int width, input int es, input int overflow);
    return 2 * positDefs::maxScale(width, es) + 2 + overflow;
  endfunction

  function automatic int quireBits(input int width, input int es, input int overflow);
    return nonFracBits(width, es, overflow) + fracBits(width, es);
  endfunction

endpackage

// ==== source/positDecoder.sv ====
/*
 * positDecoder
 *   unpacks a raw posit into sign, zero and NaR flags, scale and significand
 */
`timescale 1ns/1ps

module positDecoder #(
  parameter int WIDTH = 8,
  parameter int ES = 1
) (
  input  positDefs::posit_t posit,
  output logic sign,
  output logic isZero,
  output logic isNaR,
  output logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] scale,
  output logic [positDefs::fracBits(WIDTH, ES):0] significand
);

  localparam int SCALE_BITS = positDefs::scaleBits(WIDTH, ES);
  localparam int FRAC_BITS = positDefs::fracBits(WIDTH, ES);

  logic [WIDTH-1:0] magnitude;
  logic [WIDTH-2:0] remainder;
  logic regimeBit;
  logic counting;
  int runLength;
  int regime;
  int exponent;
  int scaleValue;

  always_comb begin
    sign = posit[WIDTH-1];
    isZero = (posit == '0);
    isNaR = (posit == {1'b1, {(WIDTH-1){1'b0}}});
    magnitude = posit[WIDTH-1] ? -posit : posit;  // regime is read from the positive form

    // length of the run of equal bits right after the sign
    regimeBit = magnitude[WIDTH-2];
    runLength = 0;
    counting = 1'b1;
    for (int i = WIDTH - 2; i >= 0; i--) begin
      if (counting && magnitude[i] == regimeBit) begin
        runLength++;
      end else begin
        counting = 1'b0;
      end
    end
    regime = regimeBit ? runLength - 1 : -runLength;

    // drop regime and terminator, exponent and fraction are then left aligned
    remainder = magnitude[WIDTH-2:0] << (runLength + 1);
    exponent = int'(remainder >> (WIDTH - 1 - ES));
    scaleValue = regime * (1 << ES) + exponent;

    if (isZero || isNaR) begin
      scale = '0;
      significand = '0;
    end else begin
      scale = SCALE_BITS'(scaleValue);
      significand = {1'b1, remainder[WIDTH-2-ES -: FRAC_BITS]};  // hidden one above the fraction
    end
  end

endmodule

// ==== source/positMultiplier.sv ====
/*
 * positMultiplier
 *   exact product of two decoded posits, normalized to one integer bit
 */
`timescale 1ns/1ps

module positMultiplier #(
  parameter int WIDTH = 8,
  parameter int ES = 1
) (
  input  logic aSign,
  input  logic aIsZero,
  input  logic aIsNaR,
  input  logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] aScale,
  input  logic [positDefs::fracBits(WIDTH, ES):0] aSignificand,
  input  logic bSign,
  input  logic bIsZero,
  input  logic bIsNaR,
  input  logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] bScale,
  input  logic [positDefs::fracBits(WIDTH, ES):0] bSignificand,
  output logic productSign,
  output logic productIsZero,
  output logic productIsNaR,
  output logic signed [positDefs::productScaleBits(WIDTH, ES)-1:0] productScale,
  output logic [positDefs::productFracBits(WIDTH, ES)-1:0] productFrac
);

  localparam int PRODUCT_SCALE_BITS = positDefs::productScaleBits(WIDTH, ES);
  localparam int PRODUCT_FRAC_BITS = positDefs::productFracBits(WIDTH, ES);

  logic [PRODUCT_FRAC_BITS-1:0] rawProduct;
  logic signed [PRODUCT_SCALE_BITS-1:0] sumScale;

  always_comb begin
    productSign = aSign ^ bSign;
    productIsNaR = aIsNaR | bIsNaR;
    productIsZero = ~productIsNaR & (aIsZero | bIsZero);  // NaR wins over zero

    rawProduct = aSignificand * bSignificand;  // value in [1, 4)
    sumScale = aScale + bScale;
    if (rawProduct[PRODUCT_FRAC_BITS-1]) begin
      productFrac = rawProduct;  // reached 2.0, the top bit becomes the integer bit
      productScale = sumScale + 1;
    end else begin
      productFrac = rawProduct << 1;
      productScale = sumScale;
    end
  end

endmodule

// ==== source/quireAccumulate.sv ====
/*
 * quireAccumulate
 *   places an exact product on the quire grid and adds or subtracts it,
 *   NaR stays set once seen
 */
`timescale 1ns/1ps

module quireAccumulate #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 2
) (
  input  logic productSign,
  input  logic productIsZero,
  input  logic productIsNaR,
  input  logic signed [positDefs::productScaleBits(WIDTH, ES)-1:0] productScale,
  input  logic [positDefs::productFracBits(WIDTH, ES)-1:0] productFrac,
  input  quireDefs::quire_t quireIn,
  input  logic narIn,
  output quireDefs::quire_t quireOut,
  output logic narOut
);

  localparam int PRODUCT_FRAC_BITS = positDefs::productFracBits(WIDTH, ES);
  localparam int QUIRE_FRAC = quireDefs::fracBits(WIDTH, ES);
  localparam int QUIRE_BITS = quireDefs::quireBits(WIDTH, ES, OVERFLOW);

  logic [QUIRE_BITS-1:0] aligned;
  logic signed [QUIRE_BITS-1:0] current;
  logic signed [QUIRE_BITS-1:0] sum;
  int shift;

  always_comb begin
    // fraction LSB weighs 2^(scale - (PRODUCT_FRAC_BITS-1)), one extra position keeps
    // the shift positive for minpos squared, whose LSB is always zero
    shift = int'(productScale) + QUIRE_FRAC - PRODUCT_FRAC_BITS + 2;
    aligned = ({{(QUIRE_BITS - PRODUCT_FRAC_BITS){1'b0}}, productFrac} << shift) >> 1;

    current = quireIn[QUIRE_BITS-1:0];
    if (productIsZero || productIsNaR) begin
      sum = current;
    end else if (productSign) begin
      sum = current - aligned;
    end else begin
      sum = current + aligned;
    end

    quireOut = sum;  // sign extended into the wider word
    narOut = narIn | productIsNaR;
  end

endmodule

// ==== source/positProcessingElement.sv ====
/*
 * positProcessingElement
 *   one systolic multiply-accumulate cell, passes a right and b down
 *   one cycle later and keeps its quire and NaR flag in registers
 */
`timescale 1ns/1ps

module positProcessingElement #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 2
) (
  input  logic clock,
  input  logic reset,
  input  logic aSign,
  input  logic aIsZero,
  input  logic aIsNaR,
  input  logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] aScale,
  input  logic [positDefs::fracBits(WIDTH, ES):0] aSignificand,
  input  logic bSign,
  input  logic bIsZero,
  input  logic bIsNaR,
  input  logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] bScale,
  input  logic [positDefs::fracBits(WIDTH, ES):0] bSignificand,
  output logic aSignRight,
  output logic aIsZeroRight,
  output logic aIsNaRRight,
  output logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] aScaleRight,
  output logic [positDefs::fracBits(WIDTH, ES):0] aSignificandRight,
  output logic bSignDown,
  output logic bIsZeroDown,
  output logic bIsNaRDown,
  output logic signed [positDefs::scaleBits(WIDTH, ES)-1:0] bScaleDown,
  output logic [positDefs::fracBits(WIDTH, ES):0] bSignificandDown,
  output quireDefs::quire_t quire,
  output logic nar
);

  logic productSign;
  logic productIsZero;
  logic productIsNaR;
  logic signed [positDefs::productScaleBits(WIDTH, ES)-1:0] productScale;
  logic [positDefs::productFracBits(WIDTH, ES)-1:0] productFrac;
  quireDefs::quire_t nextQuire;
  logic nextNar;

  positMultiplier #(.WIDTH(WIDTH), .ES(ES)) u_multiplier (
    .aSign, .aIsZero, .aIsNaR, .aScale, .aSignificand,
    .bSign, .bIsZero, .bIsNaR, .bScale, .bSignificand,
    .productSign, .productIsZero, .productIsNaR, .productScale, .productFrac
  );

  quireAccumulate #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) u_accumulate (
    .productSign, .productIsZero, .productIsNaR, .productScale, .productFrac,
    .quireIn(quire), .narIn(nar), .quireOut(nextQuire), .narOut(nextNar)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      aSignRight <= 1'b0;  // neighbours see a decoded zero, which is idle
      aIsZeroRight <= 1'b1;
      aIsNaRRight <= 1'b0;
      aScaleRight <= '0;
      aSignificandRight <= '0;
      bSignDown <= 1'b0;
      bIsZeroDown <= 1'b1;
      bIsNaRDown <= 1'b0;
      bScaleDown <= '0;
      bSignificandDown <= '0;
      quire <= '0;
      nar <= 1'b0;
    end else begin
      aSignRight <= aSign;
      aIsZeroRight <= aIsZero;
      aIsNaRRight <= aIsNaR;
      aScaleRight <= aScale;
      aSignificandRight <= aSignificand;
      bSignDown <= bSign;
      bIsZeroDown <= bIsZero;
      bIsNaRDown <= bIsNaR;
      bScaleDown <= bScale;
      bSignificandDown <= bSignificand;
      quire <= nextQuire;
      nar <= nextNar;
    end
  end

endmodule

// ==== source/positSystolicArray.sv ====
/*
 * positSystolicArray
 *   2x2 grid of posit MAC elements, rows fed from the left, columns from the top,
 *   each edge input decoded once
 */
`timescale 1ns/1ps

module positSystolicArray #(
  parameter int WIDTH = 8,
  parameter int ES = 1,
  parameter int OVERFLOW = 2
) (
  input  logic clock,
  input  logic reset,
  input  positDefs::posit_t aIn0,
  input  positDefs::posit_t aIn1,
  input  positDefs::posit_t bIn0,
  input  positDefs::posit_t bIn1,
  output quireDefs::quire_t quire00,
  output quireDefs::quire_t quire01,
  output quireDefs::quire_t quire10,
  output quireDefs::quire_t quire11,
  output logic nar00,
  output logic nar01,
  output logic nar10,
  output logic nar11
);

  localparam int SCALE_BITS = positDefs::scaleBits(WIDTH, ES);
  localparam int FRAC_BITS = positDefs::fracBits(WIDTH, ES);

  // [i][j] is the operand group entering element (i,j)
  logic aSign [2][2];
  logic aIsZero [2][2];
  logic aIsNaR [2][2];
  logic signed [SCALE_BITS-1:0] aScale [2][2];
  logic [FRAC_BITS:0] aSig [2][2];
  logic bSign [2][2];
  logic bIsZero [2][2];
  logic bIsNaR [2][2];
  logic signed [SCALE_BITS-1:0] bScale [2][2];
  logic [FRAC_BITS:0] bSig [2][2];

  positDecoder #(.WIDTH(WIDTH), .ES(ES)) u_decodeA0 (
    .posit(aIn0), .sign(aSign[0][0]), .isZero(aIsZero[0][0]), .isNaR(aIsNaR[0][0]),
    .scale(aScale[0][0]), .significand(aSig[0][0])
  );
  positDecoder #(.WIDTH(WIDTH), .ES(ES)) u_decodeA1 (
    .posit(aIn1), .sign(aSign[1][0]), .isZero(aIsZero[1][0]), .isNaR(aIsNaR[1][0]),
    .scale(aScale[1][0]), .significand(aSig[1][0])
  );
  positDecoder #(.WIDTH(WIDTH), .ES(ES)) u_decodeB0 (
    .posit(bIn0), .sign(bSign[0][0]), .isZero(bIsZero[0][0]), .isNaR(bIsNaR[0][0]),
    .scale(bScale[0][0]), .significand(bSig[0][0])
  );
  positDecoder #(.WIDTH(WIDTH), .ES(ES)) u_decodeB1 (
    .posit(bIn1), .sign(bSign[0][1]), .isZero(bIsZero[0][1]), .isNaR(bIsNaR[0][1]),
    .scale(bScale[0][1]), .significand(bSig[0][1])
  );

  positProcessingElement #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) u_pe00 (
    .clock, .reset,
    .aSign(aSign[0][0]), .aIsZero(aIsZero[0][0]), .aIsNaR(aIsNaR[0][0]),
    .aScale(aScale[0][0]), .aSignificand(aSig[0][0]),
    .bSign(bSign[0][0]), .bIsZero(bIsZero[0][0]), .bIsNaR(bIsNaR[0][0]),
    .bScale(bScale[0][0]), .bSignificand(bSig[0][0]),
    .aSignRight(aSign[0][1]), .aIsZeroRight(aIsZero[0][1]), .aIsNaRRight(aIsNaR[0][1]),
    .aScaleRight(aScale[0][1]), .aSignificandRight(aSig[0][1]),
    .bSignDown(bSign[1][0]), .bIsZeroDown(bIsZero[1][0]), .bIsNaRDown(bIsNaR[1][0]),
    .bScaleDown(bScale[1][0]), .bSignificandDown(bSig[1][0]),
    .quire(quire00), .nar(nar00)
  );

  positProcessingElement #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) u_pe01 (
    .clock, .reset,
    .aSign(aSign[0][1]), .aIsZero(aIsZero[0][1]), .aIsNaR(aIsNaR[0][1]),
    .aScale(aScale[0][1]), .aSignificand(aSig[0][1]),
    .bSign(bSign[0][1]), .bIsZero(bIsZero[0][1]), .bIsNaR(bIsNaR[0][1]),
    .bScale(bScale[0][1]), .bSignificand(bSig[0][1]),
    .aSignRight(), .aIsZeroRight(), .aIsNaRRight(), .aScaleRight(), .aSignificandRight(),
    .bSignDown(bSign[1][1]), .bIsZeroDown(bIsZero[1][1]), .bIsNaRDown(bIsNaR[1][1]),
    .bScaleDown(bScale[1][1]), .bSignificandDown(bSig[1][1]),
    .quire(quire01), .nar(nar01)
  );

  positProcessingElement #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) u_pe10 (
    .clock, .reset,
    .aSign(aSign[1][0]), .aIsZero(aIsZero[1][0]), .aIsNaR(aIsNaR[1][0]),
    .aScale(aScale[1][0]), .aSignificand(aSig[1][0]),
    .bSign(bSign[1][0]), .bIsZero(bIsZero[1][0]), .bIsNaR(bIsNaR[1][0]),
    .bScale(bScale[1][0]), .bSignificand(bSig[1][0]),
    .aSignRight(aSign[1][1]), .aIsZeroRight(aIsZero[1][1]), .aIsNaRRight(aIsNaR[1][1]),
    .aScaleRight(aScale[1][1]), .aSignificandRight(aSig[1][1]),
    .bSignDown(), .bIsZeroDown(), .bIsNaRDown(), .bScaleDown(), .bSignificandDown(),
    .quire(quire10), .nar(nar10)
  );

  // bottom right corner, its operands leave the array here
  positProcessingElement #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) u_pe11 (
    .clock, .reset,
    .aSign(aSign[1][1]), .aIsZero(aIsZero[1][1]), .aIsNaR(aIsNaR[1][1]),
    .aScale(aScale[1][1]), .aSignificand(aSig[1][1]),
    .bSign(bSign[1][1]), .bIsZero(bIsZero[1][1]), .bIsNaR(bIsNaR[1][1]),
    .bScale(bScale[1][1]), .bSignificand(bSig[1][1]),
    .aSignRight(), .aIsZeroRight(), .aIsNaRRight(), .aScaleRight(), .aSignificandRight(),
    .bSignDown(), .bIsZeroDown(), .bIsNaRDown(), .bScaleDown(), .bSignificandDown(),
    .quire(quire11), .nar(nar11)
  );

endmodule

// ==== bench/positSystolicArray_sva.sv ====
/*
 * positSystolicArraySvaChecks
 *   reset state and NaR stickiness of one processing element,
 *   bound into every positProcessingElement
 */
`timescale 1ns/1ps

module positSystolicArraySvaChecks (
  input logic clock,
  input logic reset,
  input quireDefs::quire_t quire,
  input logic nar,
  input logic aIsZeroRight,
  input logic bIsZeroDown
);

  // quire and flag are cleared one cycle after reset is seen
  quireClearedByReset: assert property (@(posedge clock) reset |=> (quire == '0 && !nar))
    else $error("quire or nar not cleared after reset");

  // pass-through registers hold a decoded zero, the idle value
  idleOperandsAfterReset: assert property (@(posedge clock) reset |=> (aIsZeroRight && bIsZeroDown))
    else $error("pass-through operands not idle after reset");

  // once set, NaR only drops through reset
  narSticky: assert property (@(posedge clock) (!reset && nar) |=> (reset || nar))
    else $error("nar fell without reset");

endmodule

bind positProcessingElement positSystolicArraySvaChecks u_svaChecks (
  .clock(clock),
  .reset(reset),
  .quire(quire),
  .nar(nar),
  .aIsZeroRight(aIsZeroRight),
  .bIsZeroDown(bIsZeroDown)
);

// ==== bench/positSystolicArrayTb.sv ====
/*
 * positSystolicArrayTb
 *   clock and reset, skewed operand streams, exact reference model,
 *   one compare process and a watchdog
 */
`timescale 1ns/1ps

module positSystolicArrayTb;

  localparam int WIDTH = 8;
  localparam int ES = 1;
  localparam int OVERFLOW = 2;
  localparam int MAX_PAIRS = 32;
  localparam int QUIRE_FRAC = 2 * ((WIDTH - 2) << ES) + 2 * (WIDTH - 3 - ES);
  localparam int TOTAL_PAIRS = 5 + 32 + 8 + 8;  // single products, random, skew, NaR
  localparam int WATCHDOG_CYCLES = TOTAL_PAIRS * 50 + 200;

  logic clock;
  logic reset;
  positDefs::posit_t aIn0, aIn1, bIn0, bIn1;
  quireDefs::quire_t quire00, quire01, quire10, quire11;
  logic nar00, nar01, nar10, nar11;

  positDefs::posit_t rowOps [2][MAX_PAIRS];  // stream per row indexed by pair k
  positDefs::posit_t colOps [2][MAX_PAIRS];
  quireDefs::quire_t expectedQuire [2][2];
  logic expectedNar [2][2];
  string checkName;
  logic checkRequest = 1'b0;

  positSystolicArray #(.WIDTH(WIDTH), .ES(ES), .OVERFLOW(OVERFLOW)) u_dut (
    .clock, .reset, .aIn0, .aIn1, .bIn0, .bIn1,
    .quire00, .quire01, .quire10, .quire11,
    .nar00, .nar01, .nar10, .nar11
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // exact value of a posit scaled onto the quire grid with NaR flagged on the side
  function automatic logic signed [127:0] decodeRef(input positDefs::posit_t p, output bit isNaR);
    logic [7:0] mag;
    logic signed [127:0] value;
    bit runBit;
    int pos;
    int run;
    int expo;
    int frac;
    int fracCount;
    int scale;
    isNaR = (p == 8'h80);
    if (p == 8'h00 || isNaR) begin
      return '0;
    end
    mag = p[7] ? 8'(-p) : p;
    runBit = mag[6];
    run = 0;
    pos = 6;
    while (pos >= 0 && mag[pos] == runBit) begin
      run++;
      pos--;
    end
    pos--;  // the terminating bit of the regime
    expo = 0;
    for (int e = 0; e < ES; e++) begin
      expo = expo * 2 + ((pos >= 0) ? int'(mag[pos]) : 0);  // missing exponent bits are zero
      pos--;
    end
    frac = 0;
    fracCount = 0;
    while (pos >= 0) begin
      frac = frac * 2 + int'(mag[pos]);
      fracCount++;
      pos--;
    end
    scale = (runBit ? run - 1 : -run) * (1 << ES) + expo;
    value = 128'((1 << fracCount) + frac);
    value = value <<< (scale - fracCount + QUIRE_FRAC);
    return p[7] ? -value : value;
  endfunction

  task automatic checkValue(input string testName, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", testName, expected, actual);
      $display("TB FAILED");
      $fatal(1, "result mismatch in %s", testName);
    end
  endtask

  // random posit kept below magnitude 16 so 32 products stay inside the guard bits
  function automatic positDefs::posit_t randomPosit();
    positDefs::posit_t magnitude;
    magnitude = 8'($urandom_range(0, 8'h6F));
    return ($urandom_range(0, 1) == 1) ? 8'(-magnitude) : magnitude;
  endfunction

  task automatic applyReset();
    @(negedge clock);
    reset = 1'b1;
    aIn0 = '0;
    aIn1 = '0;
    bIn0 = '0;
    bIn1 = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
  endtask

  // feeds pairs 0..pairs-1 with row i and column j delayed by i and j cycles
  task automatic streamPairs(input string testName, input int pairs);
    logic signed [127:0] sum;
    logic signed [127:0] va;
    logic signed [127:0] vb;
    bit naRa;
    bit naRb;
    applyReset();
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 2; j++) begin
        sum = '0;
        expectedNar[i][j] = 1'b0;
        for (int k = 0; k < pairs; k++) begin
          va = decodeRef(rowOps[i][k], naRa);
          vb = decodeRef(colOps[j][k], naRb);
          sum = sum + ((va * vb) >>> QUIRE_FRAC);
          expectedNar[i][j] = expectedNar[i][j] | naRa | naRb;
        end
        expectedQuire[i][j] = quireDefs::quire_t'(sum);
      end
    end
    for (int c = 0; c <= pairs; c++) begin
      @(negedge clock);
      aIn0 = (c < pairs) ? rowOps[0][c] : 8'h00;
      bIn0 = (c < pairs) ? colOps[0][c] : 8'h00;
      aIn1 = (c >= 1) ? rowOps[1][c - 1] : 8'h00;
      bIn1 = (c >= 1) ? colOps[1][c - 1] : 8'h00;
    end
    @(negedge clock);
    aIn0 = '0;  // idle zeros while the corner element drains
    aIn1 = '0;
    bIn0 = '0;
    bIn1 = '0;
    @(negedge clock);
    checkName = testName;
    checkRequest = 1'b1;
    wait (!checkRequest);
  endtask

  initial begin
    forever begin
      wait (checkRequest);
      checkValue({checkName, " quire00"}, expectedQuire[0][0], quire00);
      checkValue({checkName, " quire01"}, expectedQuire[0][1], quire01);
      checkValue({checkName, " quire10"}, expectedQuire[1][0], quire10);
      checkValue({checkName, " quire11"}, expectedQuire[1][1], quire11);
      checkValue({checkName, " nar00"}, 64'(expectedNar[0][0]), 64'(nar00));
      checkValue({checkName, " nar01"}, 64'(expectedNar[0][1]), 64'(nar01));
      checkValue({checkName, " nar10"}, 64'(expectedNar[1][0]), 64'(nar10));
      checkValue({checkName, " nar11"}, 64'(expectedNar[1][1]), 64'(nar11));
      checkRequest = 1'b0;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout, the array did not finish its tests within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    positDefs::posit_t exactValues [5];
    int seedValue;
    reset = 1'b1;
    aIn0 = '0;
    aIn1 = '0;
    bIn0 = '0;
    bIn1 = '0;
    seedValue = $urandom(39162);
    exactValues = '{8'h40, 8'hC0, 8'h30, 8'h7F, 8'h01};  // 1, -1, 0.5, maxpos, minpos

    streamPairs("resetState", 0);

    // every element sees a different pair, the top right one squares each value
    for (int t = 0; t < 5; t++) begin
      rowOps[0][0] = exactValues[t];
      rowOps[1][0] = exactValues[(t + 1) % 5];
      colOps[0][0] = exactValues[(t + 2) % 5];
      colOps[1][0] = exactValues[t];
      streamPairs($sformatf("singleProduct%0d", t), 1);
    end

    for (int k = 0; k < 32; k++) begin
      for (int n = 0; n < 2; n++) begin
        if (k % 4 == 3) begin
          rowOps[n][k] = 8'(-rowOps[n][k - 1]);  // cancels the product of the pair before
          colOps[n][k] = colOps[n][k - 1];
        end else begin
          rowOps[n][k] = randomPosit();
          colOps[n][k] = randomPosit();
        end
      end
    end
    streamPairs("randomAccumulate", 32);

    for (int k = 0; k < 8; k++) begin
      for (int n = 0; n < 2; n++) begin
        rowOps[n][k] = 8'(8'h40 + k * 4 + n * 2);  // distinct per row and column
        colOps[n][k] = 8'(8'h20 + k * 3 + n * 5);
      end
    end
    streamPairs("skewedStream", 8);

    for (int k = 0; k < 8; k++) begin
      for (int n = 0; n < 2; n++) begin
        rowOps[n][k] = randomPosit();
        colOps[n][k] = randomPosit();
      end
    end
    rowOps[0][3] = 8'h80;
    rowOps[1][2] = 8'h00;
    colOps[1][5] = 8'h00;
    colOps[0][6] = 8'h00;
    streamPairs("narAndZero", 8);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== positSystolicArray.f ====
source/positDefs.sv
source/quireDefs.sv
source/positDecoder.sv
source/positMultiplier.sv
source/quireAccumulate.sv
source/positProcessingElement.sv
source/positSystolicArray.sv
bench/positSystolicArray_sva.sv
bench/positSystolicArrayTb.sv
